/* sim/circle_input.txt */
# test_id centre_x centre_y radius colour expected_lit_pixels
# all fields decimal, one circle per line
1 80 60 0 7 1
2 80 60 1 1 8
3 20 100 3 2 16
4 40 30 5 2 28
5 100 70 10 3 56
6 0 0 10 4 15
7 159 119 10 5 15
8 5 60 10 6 39
9 80 3 5 1 21
10 80 60 255 7 0

/* sim/tb_circle.sv */
`timescale 1ns/1ps
`include "circle_config.svh"

module tb_circle;
  import circle_pkg::*;

  localparam int NPIX        = `SCREEN_W * `SCREEN_H;
  localparam int TEST_BUDGET = NPIX + 9 * 256 + 64;  // clear, worst case steps, margin.
  localparam int HOLD_CYCLES = 6;

  logic       clk;
  logic       rst;
  colour_t    colour;
  xcoord_t    centre_x;
  ycoord_t    centre_y;
  logic [7:0] radius;
  logic       start;
  logic       done;
  xcoord_t    vga_x;
  ycoord_t    vga_y;
  colour_t    vga_colour;
  logic       vga_plot;

  int t_id[$];
  int t_cx[$];
  int t_cy[$];
  int t_r[$];
  int t_col[$];
  int t_count[$];

  colour_t fb [NPIX];  // frame buffer model.
  bit      drawn [NPIX];
  bit      ref_lit [NPIX];
  int      ref_plots;

  string   test_name;
  colour_t test_colour;
  bit      in_test;
  int      clear_count;
  int      circle_plots;
  int      cycle_count;
  int      cycle_limit;

  circle dut0 (
    .clk        (clk),
    .rst        (rst),
    .colour     (colour),
    .centre_x   (centre_x),
    .centre_y   (centre_y),
    .radius     (radius),
    .start      (start),
    .done       (done),
    .vga_x      (vga_x),
    .vga_y      (vga_y),
    .vga_colour (vga_colour),
    .vga_plot   (vga_plot)
  );

  always #10 clk = ~clk;

  task automatic check(input string what, input int expected, input int actual);
    if (expected != actual) begin
      $display("TEST FAILED");
      $display("error %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("TEST FAILED");
      $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
      $fatal(1, "simulation timed out");
    end
  end

  // watch the pixel port and write the model.
  always @(negedge clk) begin : pixel_monitor
    int idx;
    if (!rst) begin
      check("plot strobe known", 0, $isunknown(vga_plot));
      if (vga_plot === 1'b1) begin
        check("plot outside a test", 1, in_test);
        check("plot while done", 0, done);
        if (clear_count < NPIX) begin
          check("clear x", clear_count % `SCREEN_W, int'(vga_x));
          check("clear y", clear_count / `SCREEN_W, int'(vga_y));
          check("clear colour", 0, int'(vga_colour));
          fb[clear_count]    = colour_t'(0);
          drawn[clear_count] = 1'b0;
          clear_count++;
        end else begin
          check("plot x on screen", 1, int'(vga_x) < `SCREEN_W);
          check("plot y on screen", 1, int'(vga_y) < `SCREEN_H);
          check("plot colour", int'(test_colour), int'(vga_colour));
          idx        = int'(vga_y) * `SCREEN_W + int'(vga_x);
          fb[idx]    = vga_colour;
          drawn[idx] = 1'b1;
          circle_plots++;
        end
      end
    end
  end

  task automatic mark_ref(input int px, input int py);
    if (px >= 0 && px < `SCREEN_W && py >= 0 && py < `SCREEN_H) begin
      ref_lit[py * `SCREEN_W + px] = 1'b1;
      ref_plots++;
    end
  endtask

  // midpoint circle with eight symmetric points per step.
  task automatic build_reference(input int cx, input int cy, input int r);
    int x;
    int y;
    int crit;
    bit more;
    foreach (ref_lit[i]) begin
      ref_lit[i] = 1'b0;
    end
    ref_plots = 0;
    x    = r;
    y    = 0;
    crit = 1 - r;
    more = 1'b1;
    while (more) begin
      mark_ref(cx + x, cy + y);
      mark_ref(cx + y, cy + x);
      mark_ref(cx - x, cy + y);
      mark_ref(cx - y, cy + x);
      mark_ref(cx - x, cy - y);
      mark_ref(cx - y, cy - x);
      mark_ref(cx + x, cy - y);
      mark_ref(cx + y, cy - x);
      y = y + 1;
      if (crit > 0) begin
        x    = x - 1;
        crit = crit + 2 * (y - x) + 1;
      end else begin
        crit = crit + 2 * y + 1;
      end
      more = (y <= x);
    end
  endtask

  task automatic read_tests();
    int    fd;
    int    got;
    int    fields;
    string line;
    int    id;
    int    cx;
    int    cy;
    int    r;
    int    col;
    int    cnt;
    fd = $fopen("sim/circle_input.txt", "r");
    if (fd == 0) begin
      $display("TEST FAILED");
      $display("could not open the stimulus file sim/circle_input.txt");
      $fatal(1, "missing stimulus file");
    end
    while (!$feof(fd)) begin
      line = "";
      got  = $fgets(line, fd);
      if (got > 1 && line.getc(0) != "#") begin  // skip comments and blank lines.
        fields = $sscanf(line, "%d %d %d %d %d %d", id, cx, cy, r, col, cnt);
        if (fields == 6) begin
          t_id.push_back(id);
          t_cx.push_back(cx);
          t_cy.push_back(cy);
          t_r.push_back(r);
          t_col.push_back(col);
          t_count.push_back(cnt);
        end
      end
    end
    $fclose(fd);
    if (t_id.size() == 0) begin
      $display("TEST FAILED");
      $display("the stimulus file holds no test lines");
      $fatal(1, "no tests");
    end
  endtask

  task automatic run_test(input int n);
    int lit;
    int i;
    test_name   = $sformatf("test %0d", t_id[n]);
    test_colour = colour_t'(t_col[n]);
    build_reference(t_cx[n], t_cy[n], t_r[n]);

    clear_count  = 0;
    circle_plots = 0;
    in_test      = 1'b1;
    @(posedge clk);
    centre_x <= xcoord_t'(t_cx[n]);
    centre_y <= ycoord_t'(t_cy[n]);
    radius   <= 8'(t_r[n]);
    colour   <= test_colour;
    start    <= 1'b1;

    @(negedge clk);
    while (done !== 1'b1) begin
      @(negedge clk);
    end
    check("clear plots", NPIX, clear_count);
    check("circle plots before done", ref_plots, circle_plots);

    lit = 0;
    for (i = 0; i < NPIX; i++) begin
      check($sformatf("lit at (%0d,%0d)", i % `SCREEN_W, i / `SCREEN_W),
            ref_lit[i], drawn[i]);
      if (drawn[i]) begin
        check("lit pixel colour", int'(test_colour), int'(fb[i]));
        lit++;
      end else begin
        check("unlit pixel colour", 0, int'(fb[i]));
      end
    end
    check("lit pixel count", t_count[n], lit);

    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      check("done held with start high", 1, done);
    end
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    while (done !== 1'b0) begin
      @(negedge clk);
    end
    in_test = 1'b0;
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    colour      = '0;
    centre_x    = '0;
    centre_y    = '0;
    radius      = '0;
    start       = 1'b0;
    in_test     = 1'b0;
    cycle_count = 0;
    test_name   = "reset";
    // stale contents so a missed clear shows up.
    for (int i = 0; i < NPIX; i++) begin
      fb[i]    = colour_t'(i ^ (i >> 3) ^ (i >> 6) ^ (i >> 9) ^ (i >> 12) ^ (i >> 15));
      drawn[i] = 1'b1;
    end
    read_tests();
    cycle_limit = t_id.size() * TEST_BUDGET;

    repeat (4) @(posedge clk);
    rst <= 1'b0;
    repeat (3) begin
      @(negedge clk);
      check("done after reset", 0, done);
      check("plot after reset", 0, vga_plot);
    end

    for (int n = 0; n < t_id.size(); n++) begin
      run_test(n);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

/* sources.f */
+incdir+src
src/circle_pkg.sv
src/circle_ctrl_if.sv
src/screen_fill.sv
src/circle_fsm.sv
src/circle_datapath.sv
src/circle.sv
sim/tb_circle.sv

/* src/circle.sv */
`timescale 1ns/1ps

module circle (
  input  logic                clk,
  input  logic                rst,
  input  circle_pkg::colour_t colour,
  input  circle_pkg::xcoord_t centre_x,
  input  circle_pkg::ycoord_t centre_y,
  input  logic [7:0]          radius,
  input  logic                start,
  output logic                done,
  output circle_pkg::xcoord_t vga_x,
  output circle_pkg::ycoord_t vga_y,
  output circle_pkg::colour_t vga_colour,
  output logic                vga_plot
);
  import circle_pkg::*;

  logic    fill_start;
  logic    fill_done;
  xcoord_t fill_x;
  ycoord_t fill_y;
  logic    fill_plot;
  logic    clearing;

  xcoord_t dp_x;
  ycoord_t dp_y;
  logic    dp_plot;

  colour_t colour_q;

  circle_ctrl_if ctrl_if ();

  screen_fill fill0 (
    .clk        (clk),
    .rst        (rst),
    .fill_start (fill_start),
    .fill_x     (fill_x),
    .fill_y     (fill_y),
    .fill_plot  (fill_plot),
    .fill_done  (fill_done)
  );

  circle_fsm fsm0 (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .fill_done  (fill_done),
    .fill_start (fill_start),
    .done       (done),
    .clearing   (clearing),
    .ctrl       (ctrl_if.fsm)
  );

  circle_datapath dp0 (
    .clk      (clk),
    .rst      (rst),
    .centre_x (centre_x),
    .centre_y (centre_y),
    .radius   (radius),
    .ctrl     (ctrl_if.dp),
    .px       (dp_x),
    .py       (dp_y),
    .pplot    (dp_plot)
  );

  // the colour is taken when the fsm accepts start.
  always_ff @(posedge clk) begin
    if (fill_start) begin
      colour_q <= colour;
    end
  end

  assign vga_x      = clearing ? fill_x : dp_x;
  assign vga_y      = clearing ? fill_y : dp_y;
  assign vga_colour = clearing ? colour_t'(0) : colour_q;  // clear is always black.
  assign vga_plot   = clearing ? fill_plot : dp_plot;

endmodule

/* src/circle_config.svh */
`ifndef CIRCLE_CONFIG_SVH
`define CIRCLE_CONFIG_SVH

// visible area of the frame buffer.
`define SCREEN_W 160
`define SCREEN_H 120

// coordinate widths as seen on the vga pixel port.
`define X_W 8
`define Y_W 7

`endif

/* src/circle_ctrl_if.sv */
`timescale 1ns/1ps

interface circle_ctrl_if;
  import circle_pkg::*;

  logic    load_init;   // offsets and criterion take their start values.
  octant_t octant_sel;
  logic    draw;        // present the point of octant_sel.
  logic    step;        // advance one algorithm step.
  logic    dec_x;

  offset_t offset_x;
  offset_t offset_y;
  crit_t   crit;

  modport fsm (
    output load_init,
    output octant_sel,
    output draw,
    output step,
    output dec_x,
    input  offset_x,
    input  offset_y,
    input  crit
  );

  modport dp (
    input  load_init,
    input  octant_sel,
    input  draw,
    input  step,
    input  dec_x,
    output offset_x,
    output offset_y,
    output crit
  );

endinterface

/* src/circle_datapath.sv */
`timescale 1ns/1ps
`include "circle_config.svh"

module circle_datapath (
  input  logic              clk,
  input  logic              rst,
  input  circle_pkg::xcoord_t centre_x,
  input  circle_pkg::ycoord_t centre_y,
  input  logic [7:0]        radius,
  circle_ctrl_if.dp         ctrl,
  output circle_pkg::xcoord_t px,
  output circle_pkg::ycoord_t py,
  output logic              pplot
);
  import circle_pkg::*;

  offset_t offset_x_q;
  offset_t offset_y_q;
  crit_t   crit_q;

  offset_t radius_s;
  offset_t y_next;
  offset_t x_next;
  crit_t   y_next_c;
  crit_t   diff_c;
  crit_t   crit_next;

  offset_t cx;
  offset_t cy;
  offset_t dx;
  offset_t dy;
  logic    x_neg;
  logic    y_neg;
  offset_t pt_x;
  offset_t pt_y;
  logic    on_screen;

  assign radius_s = offset_t'({2'b00, radius});

  // step update, all on the new offsets.
  assign y_next   = offset_y_q + offset_t'(1);
  assign x_next   = ctrl.dec_x ? offset_x_q - offset_t'(1) : offset_x_q;
  assign y_next_c = y_next;
  assign diff_c   = y_next - x_next;

  always_comb begin
    if (ctrl.dec_x) begin
      crit_next = crit_q + (diff_c <<< 1) + crit_t'(1);
    end else begin
      crit_next = crit_q + (y_next_c <<< 1) + crit_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.load_init) begin
      offset_x_q <= radius_s;
      offset_y_q <= offset_t'(0);
      crit_q     <= crit_t'(1) - crit_t'(radius_s);
    end else if (ctrl.step) begin
      offset_x_q <= x_next;
      offset_y_q <= y_next;
      crit_q     <= crit_next;
    end
  end

  assign ctrl.offset_x = offset_x_q;
  assign ctrl.offset_y = offset_y_q;
  assign ctrl.crit     = crit_q;

  // octant point: odd octants swap the roles of the two offsets.
  assign cx    = offset_t'({2'b00, centre_x});
  assign cy    = offset_t'({3'b000, centre_y});
  assign dx    = ctrl.octant_sel[0] ? offset_y_q : offset_x_q;
  assign dy    = ctrl.octant_sel[0] ? offset_x_q : offset_y_q;
  assign x_neg = ctrl.octant_sel[2] ^ ctrl.octant_sel[1];  // octants 2 to 5.
  assign y_neg = ctrl.octant_sel[2];                       // octants 4 to 7.

  assign pt_x = x_neg ? cx - dx : cx + dx;
  assign pt_y = y_neg ? cy - dy : cy + dy;

  assign on_screen = (pt_x >= offset_t'(0)) && (pt_x < offset_t'(`SCREEN_W)) &&
                     (pt_y >= offset_t'(0)) && (pt_y < offset_t'(`SCREEN_H));

  always_ff @(posedge clk) begin
    if (ctrl.draw) begin
      px <= pt_x[`X_W-1:0];
      py <= pt_y[`Y_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pplot <= 1'b0;
    end else begin
      pplot <= ctrl.draw && on_screen;  // off-screen points are dropped.
    end
  end

endmodule

/* src/circle_fsm.sv */
`timescale 1ns/1ps

module circle_fsm (
  input  logic           clk,
  input  logic           rst,
  input  logic           start,
  input  logic           fill_done,
  output logic           fill_start,
  output logic           done,
  output logic           clearing,
  circle_ctrl_if.fsm     ctrl
);
  import circle_pkg::*;

  circle_state_t state;
  circle_state_t state_nxt;
  octant_t       octant;

  offset_t       y_stepped;
  offset_t       x_stepped;
  logic          loop_end;

  // the loop test uses the values the step is about to write.
  assign y_stepped = ctrl.offset_y + offset_t'(1);
  assign x_stepped = ctrl.dec_x ? ctrl.offset_x - offset_t'(1) : ctrl.offset_x;
  assign loop_end  = y_stepped > x_stepped;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= IDLE;
      octant <= octant_t'(0);
    end else begin
      state <= state_nxt;
      if (state == PLOT) begin
        octant <= octant + octant_t'(1);  // wraps to 0 after octant 7.
      end else begin
        octant <= octant_t'(0);
      end
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (start) begin
          state_nxt = CLEAR;
        end
      end
      CLEAR: begin
        if (fill_done) begin
          state_nxt = INIT;
        end
      end
      INIT: begin
        state_nxt = PLOT;
      end
      PLOT: begin
        if (octant == octant_t'(7)) begin
          state_nxt = STEP;
        end
      end
      STEP: begin
        if (loop_end) begin
          state_nxt = DONE;
        end else begin
          state_nxt = PLOT;
        end
      end
      DONE: begin
        if (!start) begin
          state_nxt = IDLE;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  assign fill_start = (state == IDLE) && start;  // also the accept strobe.
  assign done       = (state == DONE);
  assign clearing   = (state == CLEAR);

  assign ctrl.load_init  = (state == INIT);
  assign ctrl.draw       = (state == PLOT);
  assign ctrl.octant_sel = octant;
  assign ctrl.step       = (state == STEP);

  // midpoint rule: move x inward once the criterion turns positive.
  assign ctrl.dec_x = (state == STEP) && (ctrl.crit > crit_t'(0));

endmodule

/* src/circle_pkg.sv */
`include "circle_config.svh"

package circle_pkg;

  typedef logic [`X_W-1:0] xcoord_t;
  typedef logic [`Y_W-1:0] ycoord_t;
  typedef logic [2:0]      colour_t;

  typedef logic signed [9:0]  offset_t;  // offset or unclipped point.
  typedef logic signed [10:0] crit_t;    // holds 1 - 255 and the largest step.

  typedef logic [2:0] octant_t;

  typedef enum logic [2:0] {
    IDLE,
    CLEAR,
    INIT,
    PLOT,
    STEP,
    DONE
  } circle_state_t;

endpackage

/* src/screen_fill.sv */
`timescale 1ns/1ps
`include "circle_config.svh"

module screen_fill (
  input  logic                clk,
  input  logic                rst,
  input  logic                fill_start,
  output circle_pkg::xcoord_t fill_x,
  output circle_pkg::ycoord_t fill_y,
  output logic                fill_plot,
  output logic                fill_done
);
  import circle_pkg::*;

  logic busy;
  logic last_x;
  logic last_y;

  assign last_x = (fill_x == xcoord_t'(`SCREEN_W - 1));
  assign last_y = (fill_y == ycoord_t'(`SCREEN_H - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      fill_done <= 1'b0;
      fill_x    <= '0;
      fill_y    <= '0;
    end else begin
      fill_done <= 1'b0;
      if (fill_start) begin
        busy   <= 1'b1;
        fill_x <= '0;
        fill_y <= '0;
      end else if (busy) begin
        if (last_x) begin
          fill_x <= '0;
          if (last_y) begin
            busy      <= 1'b0;
            fill_done <= 1'b1;  // one cycle after the last pixel.
          end else begin
            fill_y <= fill_y + 1'b1;
          end
        end else begin
          fill_x <= fill_x + 1'b1;  // x runs fastest.
        end
      end
    end
  end

  assign fill_plot = busy;

endmodule
